/* src/llapi_pkg.sv */
// Shared widths, joypad and button types, controller type codes and serial mode enum
`default_nettype none

package llapi_pkg;

	// ==============================
	// Console joypad side
	// ==============================

	// Bits 3:0 d-pad, then A, B, X, Y, L, R, Select, Start
	localparam int JOY_W = 12;
	typedef logic [JOY_W-1:0] joy_t;

	// Player slots presented to the console
	localparam int NUM_PLAYERS = 5;

	// ==============================
	// LLAPI adapter side
	// ==============================

	localparam int LLAPI_BTN_W  = 32;
	localparam int LLAPI_TYPE_W = 8;

	// One bit per HID button index
	typedef logic [LLAPI_BTN_W-1:0] llapi_btn_t;

	// Controller type codes
	localparam logic [LLAPI_TYPE_W-1:0] TYPE_NONE      = 8'd0;   // Also reported by Atari pads
	localparam logic [LLAPI_TYPE_W-1:0] TYPE_SATURN    = 8'd3;
	localparam logic [LLAPI_TYPE_W-1:0] TYPE_SATURN_3D = 8'd8;
	localparam logic [LLAPI_TYPE_W-1:0] TYPE_INVALID   = 8'd255;

	// Button indices (HID id minus one)
	localparam int BTN_FIRST   = 0;
	localparam int BTN_START   = 5;
	localparam int BTN_DPAD_LO = 24;
	localparam int BTN_DOWN    = 26;

	// User port mode
	typedef enum logic [1:0] {
		SERIAL_OFF       = 2'd0,
		SERIAL_SNAC_SNES = 2'd1,
		SERIAL_SNAC_GB   = 2'd2,
		SERIAL_LLAPI     = 2'd3
	} serial_mode_e;

endpackage

`default_nettype wire

/* src/llapi_pad_decoder.sv */
// LLAPI pad decoder with button remap, sticky presence flag, use decision and menu combo
`default_nettype none
`timescale 1ns/1ns

module llapi_pad_decoder
	import llapi_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  serial_mode_e            serial_mode,
	input  logic                    llapi_en,
	input  logic [LLAPI_TYPE_W-1:0] llapi_type,
	input  llapi_btn_t              llapi_buttons,
	output joy_t                    pad_joy,
	output logic                    pad_use,
	output logic                    pad_menu_combo
);

	logic pressed;
	logic type_valid;
	logic is_saturn;
	logic llapi_sel;
	logic pad_active;

	// ==============================
	// Presence
	// ==============================

	// Type 0 or 255 means nothing plugged in, until a button proves otherwise
	assign type_valid = (llapi_type != TYPE_NONE) && (llapi_type != TYPE_INVALID);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pressed <= 1'b0;
		end else if (|llapi_buttons) begin
			pressed <= 1'b1;
		end
	end

	assign pad_active = type_valid | pressed;
	assign llapi_sel  = (serial_mode == SERIAL_LLAPI);
	assign pad_use    = llapi_en & llapi_sel & pad_active;

	// ==============================
	// Button remap
	// ==============================

	assign is_saturn = (llapi_type == TYPE_SATURN) || (llapi_type == TYPE_SATURN_3D);

	always_comb begin
		// D-pad, face buttons and Start are common to every layout
		pad_joy[3:0] = llapi_buttons[BTN_DPAD_LO +: 4];
		pad_joy[4]   = llapi_buttons[1];
		pad_joy[5]   = llapi_buttons[BTN_FIRST];
		pad_joy[6]   = llapi_buttons[3];
		pad_joy[7]   = llapi_buttons[2];
		pad_joy[11]  = llapi_buttons[BTN_START];

		if (is_saturn) begin
			// Shoulder buttons for L/R, Z stands in for Select
			pad_joy[8]  = llapi_buttons[8];
			pad_joy[9]  = llapi_buttons[9] | llapi_buttons[7];
			pad_joy[10] = llapi_buttons[6];
		end else begin
			pad_joy[8]  = llapi_buttons[6];
			pad_joy[9]  = llapi_buttons[7];
			pad_joy[10] = llapi_buttons[4];
		end
	end

	// Down + Start + first button opens the OSD
	assign pad_menu_combo = llapi_buttons[BTN_DOWN]
		& llapi_buttons[BTN_START]
		& llapi_buttons[BTN_FIRST];

	// ==============================
	// Checks
	// ==============================

	// Sticky flag only drops through reset
	pressed_sticky: assert property (
		@(posedge clk_sys) $fell(pressed) |-> $past(reset)
	);

endmodule

`default_nettype wire

/* src/player_slot_router.sv */
// Player slot router for LLAPI and USB pads with registered OSD request
`default_nettype none
`timescale 1ns/1ns

module player_slot_router
	import llapi_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	input  joy_t pad_joy_a,
	input  joy_t pad_joy_b,
	input  logic pad_use_a,
	input  logic pad_use_b,
	input  logic pad_menu_combo_a,
	input  logic pad_menu_combo_b,
	input  joy_t joy_usb_0,
	input  joy_t joy_usb_1,
	input  joy_t joy_usb_2,
	input  joy_t joy_usb_3,
	input  joy_t joy_usb_4,
	output joy_t joy_0,
	output joy_t joy_1,
	output joy_t joy_2,
	output joy_t joy_3,
	output joy_t joy_4,
	output logic osd_request
);

	joy_t slot_next [NUM_PLAYERS];
	joy_t slot_q    [NUM_PLAYERS];

	// USB pads move down past whichever LLAPI pads are in use
	always_comb begin
		case ({pad_use_a, pad_use_b})
			2'b11: begin
				slot_next[0] = pad_joy_a;
				slot_next[1] = pad_joy_b;
				slot_next[2] = joy_usb_0;
				slot_next[3] = joy_usb_1;
				slot_next[4] = joy_usb_2;
			end
			2'b10: begin
				slot_next[0] = pad_joy_a;
				slot_next[1] = joy_usb_0;
				slot_next[2] = joy_usb_1;
				slot_next[3] = joy_usb_2;
				slot_next[4] = joy_usb_3;
			end
			2'b01: begin
				// Pad B keeps player 2, first USB pad takes player 1
				slot_next[0] = joy_usb_0;
				slot_next[1] = pad_joy_b;
				slot_next[2] = joy_usb_1;
				slot_next[3] = joy_usb_2;
				slot_next[4] = joy_usb_3;
			end
			default: begin
				slot_next[0] = joy_usb_0;
				slot_next[1] = joy_usb_1;
				slot_next[2] = joy_usb_2;
				slot_next[3] = joy_usb_3;
				slot_next[4] = joy_usb_4;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < NUM_PLAYERS; i++) begin
				slot_q[i] <= '0;
			end
			osd_request <= 1'b0;
		end else begin
			slot_q      <= slot_next;
			osd_request <= pad_menu_combo_a | pad_menu_combo_b;
		end
	end

	assign joy_0 = slot_q[0];
	assign joy_1 = slot_q[1];
	assign joy_2 = slot_q[2];
	assign joy_3 = slot_q[3];
	assign joy_4 = slot_q[4];

	// Pad A always lands in player 1 when in use
	pad_a_first: assert property (
		@(posedge clk_sys) disable iff (reset)
		pad_use_a |=> (joy_0 == $past(pad_joy_a))
	);

	reset_clears: assert property (
		@(posedge clk_sys) reset |=> (joy_0 == '0 && joy_1 == '0 && joy_2 == '0
			&& joy_3 == '0 && joy_4 == '0 && !osd_request)
	);

endmodule

`default_nettype wire

/* src/llapi_input_hub.sv */
// Controller input hub joining two LLAPI pad decoders and the player slot router
`default_nettype none
`timescale 1ns/1ns

module llapi_input_hub
	import llapi_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  serial_mode_e            serial_mode,
	input  logic                    llapi_en_a,
	input  logic                    llapi_en_b,
	input  logic [LLAPI_TYPE_W-1:0] llapi_type_a,
	input  logic [LLAPI_TYPE_W-1:0] llapi_type_b,
	input  llapi_btn_t              llapi_buttons_a,
	input  llapi_btn_t              llapi_buttons_b,
	input  joy_t                    joy_usb_0,
	input  joy_t                    joy_usb_1,
	input  joy_t                    joy_usb_2,
	input  joy_t                    joy_usb_3,
	input  joy_t                    joy_usb_4,
	output joy_t                    joy_0,
	output joy_t                    joy_1,
	output joy_t                    joy_2,
	output joy_t                    joy_3,
	output joy_t                    joy_4,
	output logic                    osd_request
);

	joy_t pad_joy_a;
	joy_t pad_joy_b;
	logic pad_use_a;
	logic pad_use_b;
	logic pad_menu_combo_a;
	logic pad_menu_combo_b;

	// ==============================
	// LLAPI ports
	// ==============================

	llapi_pad_decoder pad_a (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.serial_mode    (serial_mode),
		.llapi_en       (llapi_en_a),
		.llapi_type     (llapi_type_a),
		.llapi_buttons  (llapi_buttons_a),
		.pad_joy        (pad_joy_a),
		.pad_use        (pad_use_a),
		.pad_menu_combo (pad_menu_combo_a)
	);

	llapi_pad_decoder pad_b (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.serial_mode    (serial_mode),
		.llapi_en       (llapi_en_b),
		.llapi_type     (llapi_type_b),
		.llapi_buttons  (llapi_buttons_b),
		.pad_joy        (pad_joy_b),
		.pad_use        (pad_use_b),
		.pad_menu_combo (pad_menu_combo_b)
	);

	// ==============================
	// Slot assignment
	// ==============================

	player_slot_router slot_router (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.pad_joy_a        (pad_joy_a),
		.pad_joy_b        (pad_joy_b),
		.pad_use_a        (pad_use_a),
		.pad_use_b        (pad_use_b),
		.pad_menu_combo_a (pad_menu_combo_a),
		.pad_menu_combo_b (pad_menu_combo_b),
		.joy_usb_0        (joy_usb_0),
		.joy_usb_1        (joy_usb_1),
		.joy_usb_2        (joy_usb_2),
		.joy_usb_3        (joy_usb_3),
		.joy_usb_4        (joy_usb_4),
		.joy_0            (joy_0),
		.joy_1            (joy_1),
		.joy_2            (joy_2),
		.joy_3            (joy_3),
		.joy_4            (joy_4),
		.osd_request      (osd_request)
	);

endmodule

`default_nettype wire

/* tb/tb_llapi_input_hub.sv */
// Testbench for the LLAPI input hub, driven by vectors from a data file
`timescale 1ns/1ns
`default_nettype none

module tb_llapi_input_hub
	import llapi_pkg::*;
();

	logic                    clk_sys;
	logic                    reset;
	serial_mode_e            serial_mode;
	logic                    llapi_en_a;
	logic                    llapi_en_b;
	logic [LLAPI_TYPE_W-1:0] llapi_type_a;
	logic [LLAPI_TYPE_W-1:0] llapi_type_b;
	llapi_btn_t              llapi_buttons_a;
	llapi_btn_t              llapi_buttons_b;
	joy_t                    joy_usb_0;
	joy_t                    joy_usb_1;
	joy_t                    joy_usb_2;
	joy_t                    joy_usb_3;
	joy_t                    joy_usb_4;
	joy_t                    joy_0;
	joy_t                    joy_1;
	joy_t                    joy_2;
	joy_t                    joy_3;
	joy_t                    joy_4;
	logic                    osd_request;

	// Current vector, 19 hex columns
	logic [31:0] fields [19];
	joy_t        exp_joy [NUM_PLAYERS];
	logic        exp_osd;
	int          exp_line;
	int          line_no;

	llapi_input_hub dut0 (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.serial_mode     (serial_mode),
		.llapi_en_a      (llapi_en_a),
		.llapi_en_b      (llapi_en_b),
		.llapi_type_a    (llapi_type_a),
		.llapi_type_b    (llapi_type_b),
		.llapi_buttons_a (llapi_buttons_a),
		.llapi_buttons_b (llapi_buttons_b),
		.joy_usb_0       (joy_usb_0),
		.joy_usb_1       (joy_usb_1),
		.joy_usb_2       (joy_usb_2),
		.joy_usb_3       (joy_usb_3),
		.joy_usb_4       (joy_usb_4),
		.joy_0           (joy_0),
		.joy_1           (joy_1),
		.joy_2           (joy_2),
		.joy_3           (joy_3),
		.joy_4           (joy_4),
		.osd_request     (osd_request)
	);

	// ==============================
	// Clock
	// ==============================

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// Drive DUT inputs and keep the expected outputs of this vector
	task automatic apply_vector();
		reset           = fields[0][0];
		serial_mode     = serial_mode_e'(fields[1][1:0]);
		llapi_en_a      = fields[2][0];
		llapi_en_b      = fields[3][0];
		llapi_type_a    = fields[4][LLAPI_TYPE_W-1:0];
		llapi_type_b    = fields[5][LLAPI_TYPE_W-1:0];
		llapi_buttons_a = fields[6];
		llapi_buttons_b = fields[7];
		joy_usb_0       = fields[8][JOY_W-1:0];
		joy_usb_1       = fields[9][JOY_W-1:0];
		joy_usb_2       = fields[10][JOY_W-1:0];
		joy_usb_3       = fields[11][JOY_W-1:0];
		joy_usb_4       = fields[12][JOY_W-1:0];
		for (int i = 0; i < NUM_PLAYERS; i++) begin
			exp_joy[i] = fields[13+i][JOY_W-1:0];
		end
		exp_osd  = fields[18][0];
		exp_line = line_no;
	endtask

	task automatic check_value(input string name, input joy_t expected, input joy_t actual);
		assert (actual === expected) else begin
			$display("ERR time=%0t line=%0d %s expected=%h actual=%h",
				$time, exp_line, name, expected, actual);
			$display("Regression failed");
			$fatal(1, "Output mismatch");
		end
	endtask

	task automatic compare_outputs();
		check_value("joy_0", exp_joy[0], joy_0);
		check_value("joy_1", exp_joy[1], joy_1);
		check_value("joy_2", exp_joy[2], joy_2);
		check_value("joy_3", exp_joy[3], joy_3);
		check_value("joy_4", exp_joy[4], joy_4);
		check_value("osd_request", JOY_W'(exp_osd), JOY_W'(osd_request));
	endtask

	// ==============================
	// Stimulus
	// ==============================

	initial begin
		int    fd;
		int    n;
		int    lines_read;
		int    vec_count;
		bit    pending;
		string line;

		lines_read      = 0;
		vec_count       = 0;
		pending         = 1'b0;
		line_no         = 0;
		reset           = 1'b1;
		serial_mode     = SERIAL_OFF;
		llapi_en_a      = 1'b0;
		llapi_en_b      = 1'b0;
		llapi_type_a    = '0;
		llapi_type_b    = '0;
		llapi_buttons_a = '0;
		llapi_buttons_b = '0;
		joy_usb_0       = '0;
		joy_usb_1       = '0;
		joy_usb_2       = '0;
		joy_usb_3       = '0;
		joy_usb_4       = '0;
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;

		fd = $fopen("tb/llapi_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the test data file tb/llapi_testdata.txt");
			$display("Regression failed");
			$fatal(1, "Missing test data");
		end

		// Each vector is checked on the falling edge after the one that drove it
		while (!$feof(fd)) begin
			lines_read++;
			if (lines_read > 1000) begin
				$display("Timeout: the test data loop ran past 1000 lines");
				$display("Regression failed");
				$fatal(1, "Read loop timeout");
			end
			n = $fgets(line, fd);
			line_no++;
			if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				fields[0], fields[1], fields[2], fields[3], fields[4], fields[5],
				fields[6], fields[7], fields[8], fields[9], fields[10], fields[11],
				fields[12], fields[13], fields[14], fields[15], fields[16], fields[17],
				fields[18]);
			if (n != 19) begin
				$display("Line %0d of the test data has %0d columns instead of 19", line_no, n);
				$display("Regression failed");
				$fatal(1, "Short test data line");
			end
			@(negedge clk_sys);
			if (pending) begin
				compare_outputs();
			end
			apply_vector();
			pending = 1'b1;
			vec_count++;
		end
		@(negedge clk_sys);
		if (pending) begin
			compare_outputs();
		end
		$fclose(fd);

		if (vec_count == 0) begin
			$display("The test data file holds no vectors");
			$display("Regression failed");
			$fatal(1, "Empty test data");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tb/llapi_testdata.txt */
# rst mode en_a en_b type_a type_b buttons_a buttons_b usb0 usb1 usb2 usb3 usb4
# then expected joy_0 joy_1 joy_2 joy_3 joy_4 osd_request, all columns hex
# Reset, then serial mode off or SNAC passes USB pads through
1 0 0 0 00 00 00000000 00000000 111 222 444 888 f00 000 000 000 000 000 0
0 0 1 1 01 01 00000000 00000000 111 222 444 888 f00 111 222 444 888 f00 0
0 0 1 1 01 03 00000001 00000200 111 222 444 888 f00 111 222 444 888 f00 0
0 2 1 1 01 01 0000ffff 00000000 111 222 444 888 f00 111 222 444 888 f00 0
# Standard remap on port A
0 3 1 0 01 00 00000001 00000000 111 222 444 888 f00 020 111 222 444 888 0
0 3 1 0 01 00 00000002 00000000 111 222 444 888 f00 010 111 222 444 888 0
0 3 1 0 01 00 00000004 00000000 111 222 444 888 f00 080 111 222 444 888 0
0 3 1 0 01 00 00000008 00000000 111 222 444 888 f00 040 111 222 444 888 0
0 3 1 0 01 00 00000010 00000000 111 222 444 888 f00 400 111 222 444 888 0
0 3 1 0 01 00 00000020 00000000 111 222 444 888 f00 800 111 222 444 888 0
0 3 1 0 01 00 00000040 00000000 111 222 444 888 f00 100 111 222 444 888 0
0 3 1 0 01 00 00000080 00000000 111 222 444 888 f00 200 111 222 444 888 0
0 3 1 0 01 00 01000000 00000000 111 222 444 888 f00 001 111 222 444 888 0
0 3 1 0 01 00 02000000 00000000 111 222 444 888 f00 002 111 222 444 888 0
0 3 1 0 01 00 04000000 00000000 111 222 444 888 f00 004 111 222 444 888 0
0 3 1 0 01 00 08000000 00000000 111 222 444 888 f00 008 111 222 444 888 0
0 3 1 0 01 00 00000300 00000000 111 222 444 888 f00 000 111 222 444 888 0
0 3 1 0 01 00 050000a2 00000000 111 222 444 888 f00 a15 111 222 444 888 0
0 3 1 0 01 00 000000ff 00000000 111 222 444 888 f00 ff0 111 222 444 888 0
# Saturn and Saturn 3D remap
0 3 1 0 03 00 00000100 00000000 111 222 444 888 f00 100 111 222 444 888 0
0 3 1 0 03 00 00000200 00000000 111 222 444 888 f00 200 111 222 444 888 0
0 3 1 0 03 00 00000080 00000000 111 222 444 888 f00 200 111 222 444 888 0
0 3 1 0 03 00 00000040 00000000 111 222 444 888 f00 400 111 222 444 888 0
0 3 1 0 03 00 00000010 00000000 111 222 444 888 f00 000 111 222 444 888 0
0 3 1 0 08 00 000003c0 00000000 111 222 444 888 f00 700 111 222 444 888 0
0 3 1 0 08 00 00000030 00000000 111 222 444 888 f00 800 111 222 444 888 0
0 3 1 0 08 00 0f0003ff 00000000 111 222 444 888 f00 fff 111 222 444 888 1
# Slot shifting
0 3 1 1 01 01 00000002 01000000 111 222 444 888 f00 010 001 111 222 444 0
0 3 1 0 01 01 00000002 01000000 111 222 444 888 f00 010 111 222 444 888 0
0 3 0 1 01 01 00000002 01000000 111 222 444 888 f00 111 001 222 444 888 0
0 3 0 0 01 01 00000002 01000000 111 222 444 888 f00 111 222 444 888 f00 0
0 1 1 1 01 01 00000002 01000000 111 222 444 888 f00 111 222 444 888 f00 0
0 3 0 0 01 01 00000000 00000000 0ab 0cd 0ef 123 456 0ab 0cd 0ef 123 456 0
0 3 1 1 01 01 00000020 00000010 0ab 0cd 0ef 123 456 800 400 0ab 0cd 0ef 0
# Presence of typeless pads
1 3 1 1 00 ff 00000000 00000000 111 222 444 888 f00 000 000 000 000 000 0
0 3 1 1 00 ff 00000000 00000000 111 222 444 888 f00 111 222 444 888 f00 0
0 3 1 1 00 ff 00000001 00000000 111 222 444 888 f00 111 222 444 888 f00 0
0 3 1 1 00 ff 00000000 00000000 111 222 444 888 f00 000 111 222 444 888 0
0 3 1 1 00 ff 00000000 00000000 111 222 444 888 f00 000 111 222 444 888 0
0 3 1 1 00 ff 00000004 00000002 111 222 444 888 f00 080 111 222 444 888 0
0 3 1 1 00 ff 00000000 00000000 111 222 444 888 f00 000 000 111 222 444 0
0 3 1 1 00 ff 00000000 08000000 111 222 444 888 f00 000 008 111 222 444 0
0 0 1 1 00 ff 00000000 00000000 111 222 444 888 f00 111 222 444 888 f00 0
0 3 0 1 00 ff 00000000 00000000 111 222 444 888 f00 111 000 222 444 888 0
1 3 1 1 00 ff 00000000 00000000 111 222 444 888 f00 000 000 000 000 000 0
0 3 1 1 00 ff 00000000 00000000 111 222 444 888 f00 111 222 444 888 f00 0
0 3 1 1 00 ff 00000000 00000000 111 222 444 888 f00 111 222 444 888 f00 0
# Menu request
0 3 1 1 01 01 04000021 00000000 111 222 444 888 f00 824 000 111 222 444 1
0 3 1 1 01 01 04000020 00000000 111 222 444 888 f00 804 000 111 222 444 0
0 3 1 1 01 01 04000001 00000000 111 222 444 888 f00 024 000 111 222 444 0
0 3 1 1 01 01 00000021 00000000 111 222 444 888 f00 820 000 111 222 444 0
0 3 1 1 01 01 00000000 04000021 111 222 444 888 f00 000 824 111 222 444 1
0 3 1 1 01 01 00000000 04000020 111 222 444 888 f00 000 804 111 222 444 0
0 3 1 1 01 01 ffffffff ffffffff 111 222 444 888 f00 fff fff 111 222 444 1
0 0 1 1 01 01 04000021 00000000 111 222 444 888 f00 111 222 444 888 f00 1
0 3 0 0 01 01 00000000 04000021 111 222 444 888 f00 111 222 444 888 f00 1
0 3 1 1 01 01 00000000 00000000 111 222 444 888 f00 000 000 111 222 444 0

/* llapi_input_hub.f */
src/llapi_pkg.sv
src/llapi_pad_decoder.sv
src/player_slot_router.sv
src/llapi_input_hub.sv
tb/tb_llapi_input_hub.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench and RTL with Verilator, then run the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_llapi_input_hub \
	--Mdir obj_dir \
	-f llapi_input_hub.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_llapi_input_hub
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
fi
exit $status
